/* all.f */
+incdir+.
rvPkg.sv
alu.sv
controlUnit.sv
immGen.sv
regFile.sv
loadableRam.sv
rvCore.sv
tbRvCore.sv

/* alu.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module ALU (
    input  logic [`XLEN-1:0] ReadData1,
    input  logic [`XLEN-1:0] ReadData2,
    input  logic [`XLEN-1:0] imm32,
    input  logic             ALUSrc,
    input  rvPkg::aluOp_t    ALUOp,
    input  logic [2:0]       funct3,
    input  logic [6:0]       funct7,
    output logic [`XLEN-1:0] ALUResult,
    output logic             zero
);

    import rvPkg::*;

    // Internal control codes
    localparam logic [3:0] ctlAnd  = 4'b0000;
    localparam logic [3:0] ctlOr   = 4'b0001;
    localparam logic [3:0] ctlAdd  = 4'b0010;
    localparam logic [3:0] ctlSub  = 4'b0110;
    localparam logic [3:0] ctlNone = 4'b1111;

    logic [3:0]       aluControl;
    logic [`XLEN-1:0] operandA;
    logic [`XLEN-1:0] operandB;

    // Immediate replaces rs2 for address generation
    assign operandA = ReadData1;
    assign operandB = ALUSrc ? imm32 : ReadData2;

    //////////////////////////////////////////////////
    // ALU control decode
    //////////////////////////////////////////////////
    always_comb begin
        aluControl = ctlNone;
        case (ALUOp)
            MEM_ADD: aluControl = ctlAdd;   // base + offset
            BR_SUB:  aluControl = ctlSub;   // equality via difference
            R_FUNCT: begin
                // Only the four supported funct pairs
                if (funct7 == 7'b0000000 && funct3 == 3'b000) begin
                    aluControl = ctlAdd;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    aluControl = ctlSub;
                end else if (funct7 == 7'b0000000 && funct3 == 3'b111) begin
                    aluControl = ctlAnd;
                end else if (funct7 == 7'b0000000 && funct3 == 3'b110) begin
                    aluControl = ctlOr;
                end
            end
            default: aluControl = ctlNone;
        endcase
    end

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////
    always_comb begin
        case (aluControl)
            ctlAnd:  ALUResult = operandA & operandB;
            ctlOr:   ALUResult = operandA | operandB;
            ctlAdd:  ALUResult = operandA + operandB;
            ctlSub:  ALUResult = operandA - operandB;
            // Unknown funct yields zero
            default: ALUResult = '0;
        endcase
    end

    // Branch compare flag
    assign zero = (ALUResult == '0);

endmodule

/* controlUnit.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module controlUnit (
    input  rvPkg::instrWord_u instr,
    output logic              RegWrite,
    output logic              ALUSrc,
    output logic              MemRead,
    output logic              MemWrite,
    output logic              MemtoReg,
    output logic              Branch,
    output rvPkg::aluOp_t     ALUOp
);

    import rvPkg::*;

    //////////////////////////////////////////////////
    // Main decoder
    //////////////////////////////////////////////////
    always_comb begin
        // Safe defaults
        RegWrite = 1'b0;
        ALUSrc   = 1'b0;
        MemRead  = 1'b0;
        MemWrite = 1'b0;
        MemtoReg = 1'b0;
        Branch   = 1'b0;
        ALUOp    = MEM_ADD;

        case (instr.r.opcode)
            `OP_RTYPE: begin
                // rd <= rs1 op rs2
                RegWrite = 1'b1;
                ALUOp    = R_FUNCT;
            end
            `OP_LOAD: begin
                // rd <= mem[rs1 + imm]
                RegWrite = 1'b1;
                ALUSrc   = 1'b1;
                MemRead  = 1'b1;
                MemtoReg = 1'b1;
                ALUOp    = MEM_ADD;
            end
            `OP_STORE: begin
                // mem[rs1 + imm] <= rs2
                ALUSrc   = 1'b1;
                MemWrite = 1'b1;
                ALUOp    = MEM_ADD;
            end
            `OP_BRANCH: begin
                // Subtract, zero flag picks the target
                Branch   = 1'b1;
                ALUOp    = BR_SUB;
            end
            default: begin
                // Unknown opcode acts as a no-op
                RegWrite = 1'b0;
                MemWrite = 1'b0;
            end
        endcase
    end

endmodule

/* immGen.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module immGen (
    input  rvPkg::instrWord_u instr,
    output logic [`XLEN-1:0]  imm32
);

    //////////////////////////////////////////////////
    // Immediate assembly per format
    //////////////////////////////////////////////////
    always_comb begin
        case (instr.r.opcode)
            `OP_LOAD: begin
                imm32 = {{(`XLEN-12){instr.i.imm11_0[11]}}, instr.i.imm11_0};
            end
            `OP_STORE: begin
                // Upper and lower halves rejoined
                imm32 = {{(`XLEN-12){instr.s.imm11_5[6]}},
                         instr.s.imm11_5, instr.s.imm4_0};
            end
            `OP_BRANCH: begin
                // Halfword offset, bit 0 always clear
                imm32 = {{(`XLEN-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                         instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            // R-type and unknown need none
            default: imm32 = '0;
        endcase
    end

endmodule

/* loadableRam.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module loadableRam #(
    parameter int depth = 64
) (
    input  logic             clk,
    input  logic [`XLEN-1:0] rdAddr,
    input  logic             wrEn,
    input  logic [`XLEN-1:0] wrAddr,
    input  logic [`XLEN-1:0] wrData,
    input  logic             loadEn,
    input  logic [`XLEN-1:0] loadAddr,
    input  logic [`XLEN-1:0] loadData,
    output logic [`XLEN-1:0] rdData
);

    localparam int idxW = $clog2(depth);

    logic [`XLEN-1:0] mem [depth];
    logic [idxW-1:0]  rdIdx;
    logic [idxW-1:0]  wrIdx;
    logic [idxW-1:0]  loadIdx;

    // Word addresses fold into the array
    assign rdIdx   = idxW'(rdAddr % depth);
    assign wrIdx   = idxW'(wrAddr % depth);
    assign loadIdx = idxW'(loadAddr % depth);

    // Single write per cycle, loader first
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadIdx] <= loadData;
        end else if (wrEn) begin
            mem[wrIdx] <= wrData;
        end
    end

    // Asynchronous read
    assign rdData = mem[rdIdx];

endmodule

/* regFile.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module regFile (
    input  logic             clk,
    input  logic             arstN,
    input  logic             wrEn,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    input  logic [`XLEN-1:0] wrData,
    output logic [`XLEN-1:0] rdData1,
    output logic [`XLEN-1:0] rdData2
);

    // Architectural registers x0..x31
    logic [`XLEN-1:0] regs [32];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (wrEn && (rd != 5'd0)) begin
            // x0 never written so it reads zero forever
            regs[rd] <= wrData;
        end
    end

    // Combinational read ports
    assign rdData1 = regs[rs1];
    assign rdData2 = regs[rs2];

endmodule

/* run.sh */
#!/bin/sh
# Build and run the rvCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tbRvCore -o simRvCore

# The simulator exits nonzero on a fatal check, so the log decides
./obj_dir/simRvCore > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

/* rvCore.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module rvCore (
    input  logic             clk,
    input  logic             arstN,
    input  logic             run,
    input  logic             loadWe,
    input  logic             loadSel,
    input  logic [`XLEN-1:0] loadAddr,
    input  logic [`XLEN-1:0] loadData,
    output logic [`XLEN-1:0] pc,
    output logic             storeValid,
    output logic [`XLEN-1:0] storeAddr,
    output logic [`XLEN-1:0] storeData
);

    import rvPkg::*;

    // Fetch
    logic [`XLEN-1:0] imemData;
    instrWord_u       instr;

    // Control levels
    logic   regWrite;
    logic   aluSrc;
    logic   memRead;
    logic   memWrite;
    logic   memtoReg;
    logic   branch;
    aluOp_t aluOp;

    // Datapath
    logic [`XLEN-1:0] rdData1;
    logic [`XLEN-1:0] rdData2;
    logic [`XLEN-1:0] imm32;
    logic [`XLEN-1:0] aluResult;
    logic             aluZero;
    logic [`XLEN-1:0] dmemData;
    logic [`XLEN-1:0] dmemRdAddr;
    logic [`XLEN-1:0] wbData;

    // Next PC
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] branchTarget;
    logic [`XLEN-1:0] nextPc;
    logic             takeBranch;

    // Loader routing
    logic imemLoadEn;
    logic dmemLoadEn;

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////
    assign pcPlus4      = pc + `XLEN'd4;
    assign branchTarget = pc + imm32;
    // beq taken when rs1 - rs2 is zero
    assign takeBranch   = branch & aluZero;
    assign nextPc       = takeBranch ? branchTarget : pcPlus4;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else if (run) begin
            pc <= nextPc;
        end
    end

    // Load port goes to one memory only
    assign imemLoadEn = loadWe & ~loadSel;
    assign dmemLoadEn = loadWe & loadSel;

    //////////////////////////////////////////////////
    // Instruction memory
    //////////////////////////////////////////////////
    loadableRam #(
        .depth(`IMEM_DEPTH)
    ) imem (
        .clk      (clk),
        .rdAddr   ({2'b00, pc[`XLEN-1:2]}),
        .wrEn     (1'b0),               // Core never writes code
        .wrAddr   ('0),
        .wrData   ('0),
        .loadEn   (imemLoadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .rdData   (imemData)
    );

    // One word, four views
    assign instr = imemData;

    //////////////////////////////////////////////////
    // Decode and operand fetch
    //////////////////////////////////////////////////
    controlUnit ctrl (
        .instr    (instr),
        .RegWrite (regWrite),
        .ALUSrc   (aluSrc),
        .MemRead  (memRead),
        .MemWrite (memWrite),
        .MemtoReg (memtoReg),
        .Branch   (branch),
        .ALUOp    (aluOp)
    );

    immGen immUnit (
        .instr (instr),
        .imm32 (imm32)
    );

    // Register write only while executing
    regFile regs (
        .clk     (clk),
        .arstN   (arstN),
        .wrEn    (regWrite & run),
        .rs1     (instr.r.rs1),
        .rs2     (instr.r.rs2),
        .rd      (instr.r.rd),
        .wrData  (wbData),
        .rdData1 (rdData1),
        .rdData2 (rdData2)
    );

    //////////////////////////////////////////////////
    // Execute and memory
    //////////////////////////////////////////////////
    ALU alu (
        .ReadData1 (rdData1),
        .ReadData2 (rdData2),
        .imm32     (imm32),
        .ALUSrc    (aluSrc),
        .ALUOp     (aluOp),
        .funct3    (instr.r.funct3),
        .funct7    (instr.r.funct7),
        .ALUResult (aluResult),
        .zero      (aluZero)
    );

    // Read address parked at word 0 unless a load executes
    assign dmemRdAddr = memRead ? {2'b00, aluResult[`XLEN-1:2]} : '0;

    loadableRam #(
        .depth(`DMEM_DEPTH)
    ) dmem (
        .clk      (clk),
        .rdAddr   (dmemRdAddr),
        .wrEn     (memWrite & run),
        .wrAddr   ({2'b00, aluResult[`XLEN-1:2]}),
        .wrData   (rdData2),
        .loadEn   (dmemLoadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .rdData   (dmemData)
    );

    // Writeback select
    assign wbData = memtoReg ? dmemData : aluResult;

    // Store observation for the current instruction
    assign storeValid = memWrite & run;
    assign storeAddr  = aluResult;
    assign storeData  = rdData2;

endmodule

/* rvCore_defines.svh */
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

// Data path width
`define XLEN 32

// Memory sizes in words
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

// Major opcodes of the supported subset
`define OP_RTYPE  7'b0110011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011

// Fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

/* rvPkg.sv */
package rvPkg;

    //////////////////////////////////////////////////
    // Instruction formats, MSB first
    //////////////////////////////////////////////////

    // Register-register ops
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    // Loads, 12-bit immediate in one piece
    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    // Stores, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } sType_t;

    // Branches, scrambled immediate with implicit bit 0
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_t;

    // One fetched word, seen through whichever format applies
    typedef union packed {
        rType_t      r;
        iType_t      i;
        sType_t      s;
        bType_t      b;
        logic [31:0] raw;
    } instrWord_u;

    // Main decoder to ALU decoder hint
    typedef enum logic [1:0] {
        MEM_ADD = 2'b00,
        BR_SUB  = 2'b01,
        R_FUNCT = 2'b10
    } aluOp_t;

endpackage

/* tbRvCore.sv */
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module tbRvCore;

    // Run length and limits
    localparam int progLen = 40;
    localparam int numProgs = 8;
    localparam int timeoutCycles = numProgs * (progLen + `DMEM_DEPTH + progLen) + 200;
    localparam logic [31:0] progEnd = 32'(progLen * 4);

    logic             clk;
    logic             arstN;
    logic             run;
    logic             loadWe;
    logic             loadSel;
    logic [`XLEN-1:0] loadAddr;
    logic [`XLEN-1:0] loadData;
    logic [`XLEN-1:0] pc;
    logic             storeValid;
    logic [`XLEN-1:0] storeAddr;
    logic [`XLEN-1:0] storeData;

    // Reference machine state
    logic [31:0] prog [`IMEM_DEPTH];
    logic [31:0] mMem [`DMEM_DEPTH];
    logic [31:0] mReg [32];
    logic [31:0] mPc;
    logic [31:0] lfsrState = 32'h7fa3_1b8d;
    int          cycleCount = 0;

    rvCore UUT (
        .clk        (clk),
        .arstN      (arstN),
        .run        (run),
        .loadWe     (loadWe),
        .loadSel    (loadSel),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .pc         (pc),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int k = 0; k < count; k++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic failRun();
        $display("Checks failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            failRun();
        end
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleCount);
            failRun();
        end
    end

    task automatic resetDut();
        @(posedge clk);
        arstN  <= 1'b0;
        run    <= 1'b0;
        loadWe <= 1'b0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        for (int r = 0; r < 32; r++) begin
            mReg[r] = '0;
        end
        mPc = `RESET_PC;
    endtask

    // One load-port write per cycle
    task automatic loadWord(input logic sel, input int addr, input logic [31:0] data);
        @(posedge clk);
        loadWe   <= 1'b1;
        loadSel  <= sel;
        loadAddr <= 32'(addr);
        loadData <= data;
    endtask

    //////////////////////////////////////////////////
    // Random program builder
    //////////////////////////////////////////////////
    task automatic genProgram();
        logic [31:0] kind;
        logic [31:0] rdV;
        logic [31:0] rs1V;
        logic [31:0] rs2V;
        logic [31:0] tmp;
        logic [31:0] immB;
        logic [6:0]  f7;
        logic [2:0]  f3;
        for (int i = 0; i < progLen; i++) begin
            kind = takeBits(4);
            // Registers x0..x7 only
            rdV  = takeBits(3);
            rs1V = takeBits(3);
            rs2V = takeBits(3);
            if (kind < 6) begin
                tmp = takeBits(2);
                case (tmp[1:0])
                    2'd0: begin f7 = 7'b0000000; f3 = 3'b000; end   // add
                    2'd1: begin f7 = 7'b0100000; f3 = 3'b000; end   // sub
                    2'd2: begin f7 = 7'b0000000; f3 = 3'b111; end   // and
                    default: begin f7 = 7'b0000000; f3 = 3'b110; end // or
                endcase
                prog[i] = {f7, rs2V[4:0], rs1V[4:0], f3, rdV[4:0], `OP_RTYPE};
            end else if (kind == 6) begin
                // funct7 of 1 is outside the subset
                tmp = takeBits(3);
                prog[i] = {7'b0000001, rs2V[4:0], rs1V[4:0], tmp[2:0], rdV[4:0], `OP_RTYPE};
            end else if (kind < 10) begin
                // lw rd, 4*n(x0)
                tmp = takeBits(6);
                prog[i] = {4'b0000, tmp[5:0], 2'b00, 5'd0, 3'b010, rdV[4:0], `OP_LOAD};
            end else if (kind < 13) begin
                // sw rs2, 4*n(x0)
                tmp = takeBits(6);
                prog[i] = {4'b0000, tmp[5:3], rs2V[4:0], 5'd0, 3'b010,
                           tmp[2:0], 2'b00, `OP_STORE};
            end else if (kind < 15) begin
                // Forward beq, never past the last slot
                tmp = takeBits(3) + 32'd1;
                if (tmp > 32'(progLen - i)) begin
                    tmp = 32'(progLen - i);
                end
                immB = tmp << 2;
                prog[i] = {immB[12], immB[10:5], rs2V[4:0], rs1V[4:0], 3'b000,
                           immB[4:1], immB[11], `OP_BRANCH};
            end else begin
                // OP-IMM opcode, not in the subset
                tmp = takeBits(25);
                prog[i] = {tmp[24:0], 7'b0010011};
            end
        end
    endtask

    //////////////////////////////////////////////////
    // ISA model and per-cycle compare
    //////////////////////////////////////////////////
    task automatic checkAndStep();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] addr;
        logic [31:0] res;
        w    = prog[mPc[7:2]];
        a    = mReg[w[19:15]];
        b    = mReg[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};

        checkValue("pc", pc, mPc);
        if (w[6:0] == `OP_STORE) begin
            checkValue("storeValid", 32'(storeValid), 32'd1);
            checkValue("storeAddr", storeAddr, a + immS);
            checkValue("storeData", storeData, b);
        end else begin
            checkValue("storeValid", 32'(storeValid), 32'd0);
        end

        mPc = mPc + 32'd4;
        case (w[6:0])
            `OP_RTYPE: begin
                if (w[31:25] == 7'b0000000 && w[14:12] == 3'b000) begin
                    res = a + b;
                end else if (w[31:25] == 7'b0100000 && w[14:12] == 3'b000) begin
                    res = a - b;
                end else if (w[31:25] == 7'b0000000 && w[14:12] == 3'b111) begin
                    res = a & b;
                end else if (w[31:25] == 7'b0000000 && w[14:12] == 3'b110) begin
                    res = a | b;
                end else begin
                    res = '0;   // unsupported funct
                end
                if (w[11:7] != 5'd0) begin
                    mReg[w[11:7]] = res;
                end
            end
            `OP_LOAD: begin
                addr = a + immI;
                if (w[11:7] != 5'd0) begin
                    mReg[w[11:7]] = mMem[addr[7:2]];
                end
            end
            `OP_STORE: begin
                addr = a + immS;
                mMem[addr[7:2]] = b;
            end
            `OP_BRANCH: begin
                if (a == b) begin
                    mPc = mPc - 32'd4 + immB;
                end
            end
            default: begin
                // Unknown opcode only moves the PC
            end
        endcase
    endtask

    task automatic runProgram();
        @(posedge clk);
        run <= 1'b1;
        while (mPc < progEnd) begin
            // Outputs settle mid-cycle
            @(negedge clk);
            checkAndStep();
            @(posedge clk);
            if (mPc >= progEnd) begin
                run <= 1'b0;
            end
        end
        // Idle core keeps its PC
        repeat (3) begin
            @(negedge clk);
            checkValue("pc", pc, progEnd);
            checkValue("storeValid", 32'(storeValid), 32'd0);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        logic [31:0] d;
        arstN    <= 1'b0;
        run      <= 1'b0;
        loadWe   <= 1'b0;
        loadSel  <= 1'b0;
        loadAddr <= '0;
        loadData <= '0;

        for (int p = 0; p < numProgs; p++) begin
            resetDut();
            @(negedge clk);
            checkValue("pc", pc, `RESET_PC);
            checkValue("storeValid", 32'(storeValid), 32'd0);

            genProgram();
            for (int i = 0; i < progLen; i++) begin
                loadWord(1'b0, i, prog[i]);
            end
            // Fresh data each program
            for (int j = 0; j < `DMEM_DEPTH; j++) begin
                d = takeBits(32);
                mMem[j] = d;
                loadWord(1'b1, j, d);
            end
            @(posedge clk);
            loadWe <= 1'b0;

            // Loading must not move the PC
            @(negedge clk);
            checkValue("pc", pc, `RESET_PC);
            runProgram();
        end

        $display("All checks passed");
        $finish;
    end

endmodule
